//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    // addresses and data are one word wide on both buses
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one enable per byte lane, lane 0 is bits 7:0
    typedef logic [3:0] strobe_t;

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,   // single byte
        MSIZE4 = 2'd2    // full word
    } msize_t;

    // boot rom entry in kseg1, so the first fetches go out uncached
    localparam addr_t RESET_PC = 32'hbfc00000;

endpackage

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    // instruction field layout
    localparam int OPC_LSB = 26;
    localparam int OPC_W   = 6;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int REG_W   = 5;
    localparam int IMM_W   = 16;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,   // signed compare
        ALU_LUI    // b already holds the upper immediate
    } alu_op_t;

endpackage

`default_nettype wire

//--- addr_translate.sv
`default_nettype none

module addr_translate (
    input  bus_pkg::addr_t vaddr,
    output bus_pkg::addr_t paddr,
    output logic           uncached
);

    // low 28 bits pass straight through in every segment
    assign paddr[27:0] = vaddr[27:0];

    always_comb begin
        case (vaddr[31:28])
            4'h8, 4'ha: paddr[31:28] = 4'h0;  // kseg0 / kseg1, lower half
            4'h9, 4'hb: paddr[31:28] = 4'h1;  // kseg0 / kseg1, upper half
            default:    paddr[31:28] = vaddr[31:28]; // useg, ksseg, kseg3
        endcase
    end

    // only kseg1 bypasses the cache
    always_comb begin
        case (vaddr[31:28])
            4'ha, 4'hb: uncached = 1'b1;
            default:    uncached = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
    input  logic           clk,
    input  logic           rst,
    input  logic [4:0]     ra1,
    input  logic [4:0]     ra2,
    output bus_pkg::word_t rd1,
    output bus_pkg::word_t rd2,
    input  logic           we,
    input  logic [4:0]     wa,
    input  bus_pkg::word_t wd
);
    import bus_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin  // $zero never changes
            regs[wa] <= wd;
        end
    end

    // combinational read, a write lands before the next reader sees it
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t op,
    input  bus_pkg::word_t    a,
    input  bus_pkg::word_t    b,
    output bus_pkg::word_t    y,
    output logic              zero
);
    import bus_pkg::*;
    import mips_pkg::*;

    word_t diff;
    logic  lt;

    assign diff = a - b;

    // signed less-than from the sign bits and the difference
    always_comb begin
        if (a[31] != b[31]) begin
            lt = a[31];        // negative side is smaller
        end else begin
            lt = diff[31];
        end
    end

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = diff;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'd0, lt};
            ALU_LUI: y = b;   // upper immediate built by decode
            default: y = '0;
        endcase
    end

    // equal operands, used by beq/bne
    assign zero = (diff == '0);

endmodule

`default_nettype wire

//--- mips_core.sv
`default_nettype none

module mips_core #(
    parameter bus_pkg::addr_t reset_pc = bus_pkg::RESET_PC
) (
    input  logic             clk,
    input  logic             rst,
    output logic             ireq_valid,
    output bus_pkg::addr_t   ireq_vaddr,
    input  logic             iresp_ok,
    input  bus_pkg::word_t   iresp_data,
    output logic             dreq_valid,
    output bus_pkg::addr_t   dreq_vaddr,
    output logic             dreq_write,
    output bus_pkg::msize_t  dreq_size,
    output bus_pkg::strobe_t dreq_strobe,
    output bus_pkg::word_t   dreq_data,
    input  logic             dresp_ok,
    input  bus_pkg::word_t   dresp_data
);
    import bus_pkg::*;
    import mips_pkg::*;

    // fetch state
    addr_t pc;                        // address of the fetch in flight or next
    addr_t f_target;                  // redirect waiting on a flushed fetch
    logic  f_flush;
    logic  hold_valid;
    word_t hold_instr;
    addr_t hold_pc;

    // execute state
    logic  e_valid;
    word_t e_instr;
    addr_t e_pc;

    opcode_t    opc;
    funct_t     fn;
    logic [4:0] rs, rt, rd, wr_addr;
    word_t      imm_sext, imm_val, rs_val, rt_val, alu_b, alu_y, rf_wd, br_target;
    alu_op_t    alu_op;
    logic       use_imm, wr_en, is_load, is_store, is_byte, is_branch, br_ne;
    logic       alu_zero, e_stall, take, rf_we;

    assign opc = opcode_t'(e_instr[OPC_LSB +: OPC_W]);
    assign fn  = funct_t'(e_instr[OPC_W-1:0]);
    assign rs  = e_instr[RS_LSB +: REG_W];
    assign rt  = e_instr[RT_LSB +: REG_W];
    assign rd  = e_instr[RD_LSB +: REG_W];
    assign imm_sext = {{(32-IMM_W){e_instr[IMM_W-1]}}, e_instr[IMM_W-1:0]};

    always_comb begin
        alu_op    = ALU_ADD;
        imm_val   = imm_sext;
        use_imm   = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = rt;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_byte   = 1'b0;
        is_branch = 1'b0;
        br_ne     = 1'b0;
        case (opc)
            OP_SPECIAL: begin
                wr_addr = rd;
                wr_en   = 1'b1;
                case (fn)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: wr_en = 1'b0;   // unsupported, acts as nop
                endcase
            end
            OP_ADDIU: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_val = {{(32-IMM_W){1'b0}}, e_instr[IMM_W-1:0]};  // zero extended
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_val = {e_instr[IMM_W-1:0], {(32-IMM_W){1'b0}}};
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_LW: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
                is_load = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_SB: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            OP_BEQ: begin
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
            end
            OP_BNE: begin
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
                br_ne     = 1'b1;
            end
            default: ;
        endcase
    end

    regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .ra1 (rs),
        .ra2 (rt),
        .rd1 (rs_val),
        .rd2 (rt_val),
        .we  (rf_we),
        .wa  (wr_addr),
        .wd  (rf_wd)
    );

    assign alu_b = use_imm ? imm_val : rt_val;

    alu u_alu (
        .op   (alu_op),
        .a    (rs_val),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // memory ops sit in execute until the data bus answers
    assign e_stall   = e_valid & (is_load | is_store) & ~dresp_ok;
    assign take      = e_valid & is_branch & (alu_zero ^ br_ne);
    assign br_target = e_pc + 32'd4 + {imm_sext[29:0], 2'b00};
    assign rf_we     = e_valid & ~e_stall & wr_en;
    assign rf_wd     = is_load ? dresp_data : alu_y;

    // data bus request, fields stay put while stalled
    assign dreq_valid  = e_valid & (is_load | is_store);
    assign dreq_vaddr  = alu_y;
    assign dreq_write  = is_store;
    assign dreq_size   = is_byte ? MSIZE1 : MSIZE4;
    assign dreq_strobe = !is_store ? 4'b0000 :
                         is_byte   ? strobe_t'(4'b0001) << alu_y[1:0] : 4'b1111;
    assign dreq_data   = is_byte ? word_t'(rt_val[7:0]) << {alu_y[1:0], 3'b000} : rt_val;

    assign ireq_vaddr = pc;

    // fetch stage
    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_pc;
            ireq_valid <= 1'b0;
            f_flush    <= 1'b0;
            hold_valid <= 1'b0;
        end else if (take) begin
            hold_valid <= 1'b0;     // held instruction is on the wrong path
            if (ireq_valid && !iresp_ok) begin
                f_flush  <= 1'b1;   // let the old fetch finish, then redirect
                f_target <= br_target;
            end else begin
                pc         <= br_target;
                ireq_valid <= 1'b1;
            end
        end else if (iresp_ok) begin
            if (f_flush) begin
                pc         <= f_target;
                f_flush    <= 1'b0;
                ireq_valid <= 1'b1;
            end else begin
                pc <= pc + 32'd4;
                if (e_stall) begin
                    hold_valid <= 1'b1;
                    hold_instr <= iresp_data;
                    hold_pc    <= pc;
                    ireq_valid <= 1'b0;   // no new fetch until execute drains
                end else begin
                    ireq_valid <= 1'b1;
                end
            end
        end else if (!ireq_valid && !e_stall) begin
            hold_valid <= 1'b0;     // first fetch after reset, or hold moved on
            ireq_valid <= 1'b1;
        end
    end

    // execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
        end else if (!e_stall) begin
            if (take) begin
                e_valid <= 1'b0;
            end else if (hold_valid) begin
                e_valid <= 1'b1;
                e_instr <= hold_instr;
                e_pc    <= hold_pc;
            end else if (iresp_ok && !f_flush) begin
                e_valid <= 1'b1;
                e_instr <= iresp_data;
                e_pc    <= pc;
            end else begin
                e_valid <= 1'b0;   // bubble
            end
        end
    end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`default_nettype none

module bus_arbiter #(
    parameter bit data_first = 1'b1
) (
    input  logic             clk,
    input  logic             rst,
    // instruction peer
    input  logic             ireq_valid,
    input  bus_pkg::addr_t   ireq_addr,
    input  logic             uncached_i,
    output bus_pkg::word_t   iresp_data,
    output logic             iresp_ok,
    // data peer
    input  logic             dreq_valid,
    input  bus_pkg::addr_t   dreq_addr,
    input  logic             dreq_write,
    input  bus_pkg::msize_t  dreq_size,
    input  bus_pkg::strobe_t dreq_strobe,
    input  bus_pkg::word_t   dreq_data,
    input  logic             uncached_d,
    output bus_pkg::word_t   dresp_data,
    output logic             dresp_ok,
    // memory port
    output logic             mem_valid,
    output bus_pkg::addr_t   mem_addr,
    output logic             mem_write,
    output bus_pkg::strobe_t mem_strobe,
    output bus_pkg::word_t   mem_wdata,
    output logic             mem_uncached,
    input  bus_pkg::word_t   mem_rdata,
    input  logic             mem_ready
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INST,
        ST_DATA
    } state_t;

    state_t state;
    logic   sel_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dreq_valid && (data_first || !ireq_valid)) begin
                        state <= ST_DATA;
                    end else if (ireq_valid) begin
                        state <= ST_INST;
                    end
                end
                default: begin
                    if (mem_ready) begin
                        state <= ST_IDLE;   // requester drops or renews next cycle
                    end
                end
            endcase
        end
    end

    assign sel_d = (state == ST_DATA);

    // requesters hold their fields, so the grant alone picks the mux leg
    assign mem_valid    = (state != ST_IDLE);
    assign mem_addr     = sel_d ? dreq_addr : ireq_addr;
    assign mem_write    = sel_d & dreq_write;
    assign mem_wdata    = dreq_data;
    assign mem_uncached = sel_d ? uncached_d : uncached_i;

    // word stores enable every lane, byte stores keep their one-hot lane
    assign mem_strobe = !mem_write            ? 4'b0000 :
                        (dreq_size == MSIZE4) ? 4'b1111 : dreq_strobe;

    assign iresp_ok   = (state == ST_INST) & mem_ready;
    assign dresp_ok   = sel_d & mem_ready;
    assign iresp_data = mem_rdata;
    assign dresp_data = mem_rdata;

endmodule

`default_nettype wire

//--- soc_top.sv
`default_nettype none

module soc_top #(
    parameter bus_pkg::addr_t reset_pc   = bus_pkg::RESET_PC,
    parameter bit             data_first = 1'b1
) (
    input  logic             clk,
    input  logic             rst,
    output logic             mem_valid,
    output logic             mem_write,
    output logic             mem_uncached,
    output bus_pkg::addr_t   mem_addr,
    output bus_pkg::strobe_t mem_strobe,
    output bus_pkg::word_t   mem_wdata,
    input  bus_pkg::word_t   mem_rdata,
    input  logic             mem_ready
);
    import bus_pkg::*;

    logic    ireq_valid, iresp_ok, uncached_i;
    addr_t   ireq_vaddr, ireq_paddr;
    word_t   iresp_data;

    logic    dreq_valid, dreq_write, dresp_ok, uncached_d;
    addr_t   dreq_vaddr, dreq_paddr;
    msize_t  dreq_size;
    strobe_t dreq_strobe;
    word_t   dreq_data, dresp_data;

    mips_core #(
        .reset_pc (reset_pc)
    ) core (
        .clk, .rst,
        .ireq_valid, .ireq_vaddr, .iresp_ok, .iresp_data,
        .dreq_valid, .dreq_vaddr, .dreq_write, .dreq_size,
        .dreq_strobe, .dreq_data, .dresp_ok, .dresp_data
    );

    addr_translate itrans (
        .vaddr    (ireq_vaddr),
        .paddr    (ireq_paddr),
        .uncached (uncached_i)
    );

    addr_translate dtrans (
        .vaddr    (dreq_vaddr),
        .paddr    (dreq_paddr),
        .uncached (uncached_d)
    );

    bus_arbiter #(
        .data_first (data_first)
    ) arbiter (
        .clk, .rst,
        .ireq_valid, .ireq_addr (ireq_paddr), .uncached_i, .iresp_data, .iresp_ok,
        .dreq_valid, .dreq_addr (dreq_paddr), .dreq_write, .dreq_size,
        .dreq_strobe, .dreq_data, .uncached_d, .dresp_data, .dresp_ok,
        .mem_valid, .mem_addr, .mem_write, .mem_strobe, .mem_wdata,
        .mem_uncached, .mem_rdata, .mem_ready
    );

endmodule

`default_nettype wire

//--- tb_soc.sv
`default_nettype none

module tb_soc;
    import bus_pkg::*;
    import mips_pkg::*;

    localparam int NUM_STORES = 15;
    localparam int LOG_DEPTH  = 32;
    localparam int RST_CYCLES = 16;

    logic    clk;
    logic    rst;
    logic    mem_valid, mem_write, mem_uncached;
    addr_t   mem_addr;
    strobe_t mem_strobe;
    word_t   mem_wdata;
    word_t   mem_rdata = '0;
    logic    mem_ready = 1'b0;

    // state owned by the memory process
    word_t       mem [128];          // 0..63 data at 0x0, 64..127 code at 0x1fc00000
    logic [6:0]  emit_ptr;
    logic [31:0] seed = 32'h8ced;
    logic [1:0]  wait_left;
    logic        in_txn;
    addr_t       t_addr;
    logic        t_write, t_unc;
    strobe_t     t_strobe;
    word_t       t_wdata;
    int          port_errors = 0;

    // write transactions as seen on the port
    int      wr_count = 0;
    addr_t   log_addr [LOG_DEPTH];
    strobe_t log_strobe [LOG_DEPTH];
    word_t   log_data [LOG_DEPTH];
    logic    log_unc [LOG_DEPTH];

    // expected store sequence
    string   exp_name [NUM_STORES];
    addr_t   exp_addr [NUM_STORES];
    strobe_t exp_strobe [NUM_STORES];
    word_t   exp_data [NUM_STORES];
    logic    exp_unc [NUM_STORES];
    int      store_errors = 0;

    soc_top uut (
        .clk, .rst,
        .mem_valid, .mem_write, .mem_uncached, .mem_addr,
        .mem_strobe, .mem_wdata, .mem_rdata, .mem_ready
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [6:0] mem_index(input addr_t a);
        return {a[28], a[7:2]};
    endfunction

    function automatic word_t r_type(input funct_t fn, input int rd, input int rs, input int rt);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input int rt, input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic emit(input word_t instr);
        mem[emit_ptr] = instr;
        emit_ptr = emit_ptr + 7'd1;
    endtask

    task automatic load_program();
        for (int i = 0; i < 128; i++) begin
            mem[i] = '0;
        end
        mem[16] = 32'h12345678;               // read by lw at phys 0x40
        emit_ptr = 7'd64;
        emit(i_type(OP_LUI, 1, 0, 'h8000));    // $1 = kseg0 data base
        emit(i_type(OP_LUI, 2, 0, 'ha000));    // $2 = kseg1 data base
        emit(i_type(OP_ADDIU, 3, 0, 100));
        emit(i_type(OP_ADDIU, 4, 0, -7));
        emit(i_type(OP_SW, 4, 1, 'h00));
        emit(r_type(FN_ADDU, 5, 3, 4));
        emit(i_type(OP_SW, 5, 1, 'h04));
        emit(r_type(FN_SUBU, 6, 4, 3));
        emit(i_type(OP_SW, 6, 2, 'h08));
        emit(i_type(OP_LUI, 7, 0, 'h1234));
        emit(i_type(OP_ORI, 7, 7, 'hf0f0));
        emit(i_type(OP_SW, 7, 1, 'h0c));
        emit(i_type(OP_ORI, 8, 0, 'hff00));
        emit(r_type(FN_AND, 9, 7, 8));
        emit(i_type(OP_SW, 9, 1, 'h10));
        emit(r_type(FN_OR, 10, 3, 8));
        emit(i_type(OP_SW, 10, 1, 'h14));
        emit(r_type(FN_SLT, 11, 4, 3));
        emit(i_type(OP_SW, 11, 1, 'h18));
        emit(r_type(FN_SLT, 12, 3, 4));
        emit(i_type(OP_SW, 12, 2, 'h1c));
        emit(i_type(OP_LW, 13, 2, 'h40));
        emit(i_type(OP_SW, 13, 1, 'h20));
        emit(i_type(OP_SB, 7, 1, 'h25));
        emit(i_type(OP_SB, 3, 2, 'h27));
        emit(i_type(OP_ORI, 14, 0, 'hdead));   // poison value
        emit(i_type(OP_BEQ, 3, 3, 1));          // taken
        emit(i_type(OP_SW, 14, 1, 'h50));
        emit(i_type(OP_SW, 3, 1, 'h28));
        emit(i_type(OP_BNE, 4, 3, 1));          // taken
        emit(i_type(OP_SW, 14, 1, 'h54));
        emit(i_type(OP_SW, 5, 1, 'h2c));
        emit(i_type(OP_BEQ, 4, 3, 1));          // falls through
        emit(i_type(OP_SW, 10, 1, 'h30));
        emit(i_type(OP_BNE, 3, 3, 1));          // falls through
        emit(i_type(OP_SW, 11, 2, 'h34));
        emit(i_type(OP_BEQ, 0, 0, -1));         // spin here
    endtask

    task automatic set_row(input int i, input string name, input addr_t a, input strobe_t s,
                           input word_t d, input logic u);
        exp_name[i]   = name;
        exp_addr[i]   = a;
        exp_strobe[i] = s;
        exp_data[i]   = d;
        exp_unc[i]    = u;
    endtask

    // memory model with 0..3 random wait states per transaction
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            in_txn = 1'b0;
            wr_count = 0;
            load_program();
        end else if (mem_ready) begin
            mem_ready <= 1'b0;    // transaction retires on this edge
            in_txn = 1'b0;
        end else if (mem_valid) begin
            if (!in_txn) begin
                in_txn   = 1'b1;
                t_addr   = mem_addr;
                t_write  = mem_write;
                t_strobe = mem_strobe;
                t_wdata  = mem_wdata;
                t_unc    = mem_uncached;
                seed = lcg_next(seed);
                wait_left = seed[17:16];
                assert (mem_write ? mem_addr[31:8] == '0 :
                        (mem_addr[31:20] == 12'h1fc && mem_uncached) || mem_addr[31:8] == '0)
                else begin
                    $display("access to unexpected address %h (write %b, uncached %b)",
                             mem_addr, mem_write, mem_uncached);
                    port_errors++;
                end
            end
            assert (mem_addr == t_addr && mem_write == t_write && mem_strobe == t_strobe &&
                    mem_wdata == t_wdata && mem_uncached == t_unc)
            else begin
                $display("memory request at %h changed before mem_ready", t_addr);
                port_errors++;
            end
            assert (mem_write ? mem_strobe != 4'b0000 : mem_strobe == 4'b0000) else begin
                $display("read and write mixed on the memory port at %h", mem_addr);
                port_errors++;
            end
            if (wait_left == 2'd0) begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_strobe[b]) begin
                            mem[mem_index(mem_addr)][b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                    end
                    if (wr_count < LOG_DEPTH) begin
                        log_addr[wr_count]   = mem_addr;
                        log_strobe[wr_count] = mem_strobe;
                        log_data[wr_count]   = mem_wdata;
                        log_unc[wr_count]    = mem_uncached;
                    end
                    wr_count++;
                end else begin
                    mem_rdata <= mem[mem_index(mem_addr)];
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    // watchdog
    initial begin
        repeat (RST_CYCLES + NUM_STORES * 200) @(posedge clk);
        $display("timeout: the store sequence did not complete in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        int row_bad;
        rst = 1'b1;
        set_row(0,  "addiu",     32'h00000000, 4'b1111, 32'hfffffff9, 1'b0);
        set_row(1,  "addu",      32'h00000004, 4'b1111, 32'h0000005d, 1'b0);
        set_row(2,  "subu",      32'h00000008, 4'b1111, 32'hffffff95, 1'b1);
        set_row(3,  "lui_ori",   32'h0000000c, 4'b1111, 32'h1234f0f0, 1'b0);
        set_row(4,  "and",       32'h00000010, 4'b1111, 32'h0000f000, 1'b0);
        set_row(5,  "or",        32'h00000014, 4'b1111, 32'h0000ff64, 1'b0);
        set_row(6,  "slt_lt",    32'h00000018, 4'b1111, 32'h00000001, 1'b0);
        set_row(7,  "slt_ge",    32'h0000001c, 4'b1111, 32'h00000000, 1'b1);
        set_row(8,  "lw_copy",   32'h00000020, 4'b1111, 32'h12345678, 1'b0);
        set_row(9,  "sb_lane1",  32'h00000025, 4'b0010, 32'h0000f000, 1'b0);
        set_row(10, "sb_lane3",  32'h00000027, 4'b1000, 32'h64000000, 1'b1);
        set_row(11, "beq_taken", 32'h00000028, 4'b1111, 32'h00000064, 1'b0);
        set_row(12, "bne_taken", 32'h0000002c, 4'b1111, 32'h0000005d, 1'b0);
        set_row(13, "beq_fall",  32'h00000030, 4'b1111, 32'h0000ff64, 1'b0);
        set_row(14, "bne_fall",  32'h00000034, 4'b1111, 32'h00000001, 1'b1);
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_STORES; i++) begin
            while (wr_count <= i) @(negedge clk);
            row_bad = 0;
            assert (log_addr[i] == exp_addr[i]) else begin
                $display("ERR %s: addr expected %h actual %h",
                         exp_name[i], exp_addr[i], log_addr[i]);
                row_bad++;
            end
            assert (log_strobe[i] == exp_strobe[i]) else begin
                $display("ERR %s: strobe expected %b actual %b",
                         exp_name[i], exp_strobe[i], log_strobe[i]);
                row_bad++;
            end
            assert (log_data[i] == exp_data[i]) else begin
                $display("ERR %s: data expected %h actual %h",
                         exp_name[i], exp_data[i], log_data[i]);
                row_bad++;
            end
            assert (log_unc[i] == exp_unc[i]) else begin
                $display("ERR %s: uncached expected %b actual %b",
                         exp_name[i], exp_unc[i], log_unc[i]);
                row_bad++;
            end
            store_errors += row_bad;
            if (row_bad == 0) $display("%s: ok", exp_name[i]);
            else $display("%s: %0d mismatches", exp_name[i], row_bad);
        end

        // the core spins on its last branch, so nothing more may be written
        repeat (50) @(negedge clk);
        assert (wr_count == NUM_STORES) else begin
            $display("extra stores on the memory port, %0d beyond the expected sequence",
                     wr_count - NUM_STORES);
            store_errors++;
        end
        if (wr_count == NUM_STORES) $display("no_extra_stores: ok");
        else $display("no_extra_stores: mismatch");
        if (port_errors == 0) $display("port_protocol: ok");
        else $display("port_protocol: %0d violations", port_errors);

        $display("%0d tests run, %0d errors", NUM_STORES + 2, store_errors + port_errors);
        if (store_errors + port_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
bus_pkg.sv
mips_pkg.sv
addr_translate.sv
regfile.sv
alu.sv
mips_core.sv
bus_arbiter.sv
soc_top.sv
tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# build the SoC with its testbench in Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc \
    -f project.f \
    -o tb_soc \
    || { echo "verilator build failed"; exit 1; }

result=$(./obj_dir/tb_soc)
echo "$result"

echo "$result" | grep -qx "Test passed" \
    && { echo "simulation ok"; exit 0; } \
    || { echo "simulation reported a failure"; exit 1; }
